//--- cpu_system.f
+incdir+include
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/cpu_datapath.sv
hw/cpu_controller.sv
hw/cpu_core.sv
hw/data_ram.sv
hw/cpu_system.sv
sim/cpu_system_tb.sv

//--- hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module alu
  import isa_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   y,
  output flags_t  flags
);

  localparam int MSB = `CPU_WORD_W - 1;

  always_comb begin
    flags.v = 1'b0;
    case (op)
      ALU_ADD: begin
        y = a + b;
        // overflow when same-sign operands flip the result sign
        flags.v = (a[MSB] == b[MSB]) && (y[MSB] != a[MSB]);
      end
      ALU_SUB: begin
        y = a - b;
        flags.v = (a[MSB] != b[MSB]) && (y[MSB] != a[MSB]);
      end
      ALU_AND: y = a & b;
      default: y = ~b;
    endcase
    flags.n = y[MSB];
    flags.z = (y == '0);
  end

endmodule

`default_nettype wire

//--- hw/cpu_controller.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_controller
  import isa_pkg::*, ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  decoded_instr_t instr,
  output dp_ctrl_t       dp,
  output mem_ctrl_t      mem,
  output logic           halted
);

  ctrl_state_e state;
  ctrl_state_e next_state;
  logic        mov_imm;
  logic        is_cmp;
  logic        is_mem;
  logic        is_str;

  assign mov_imm = (instr.opcode == OP_MOV) && (instr.op == ALU_AND);
  assign is_cmp  = (instr.opcode == OP_ALU) && (instr.op == ALU_SUB);
  assign is_str  = (instr.opcode == OP_STR);
  assign is_mem  = (instr.opcode == OP_LDR) || is_str;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_RESET:  next_state = S_FETCH;
      S_FETCH:  next_state = S_DECODE;
      S_DECODE: begin
        case (instr.opcode)
          OP_MOV:         next_state = mov_imm ? S_WRITE : S_LOAD_B;
          OP_ALU:         next_state = (instr.op == ALU_MVN) ? S_LOAD_B : S_LOAD_A;
          OP_LDR, OP_STR: next_state = S_EXEC;
          OP_HALT:        next_state = S_HALT;
          default:        next_state = S_FETCH;
        endcase
      end
      S_LOAD_A: next_state = S_LOAD_B;
      S_LOAD_B: next_state = S_EXEC;
      S_EXEC: begin
        if (is_mem) begin
          next_state = S_MEM_ADDR;
        end else if (is_cmp) begin
          next_state = S_FETCH;
        end else begin
          next_state = S_WRITE;
        end
      end
      S_WRITE:    next_state = S_FETCH;
      S_MEM_ADDR: next_state = is_str ? S_MEM_WR : S_MEM_RD;
      S_MEM_RD:   next_state = S_MEM_WB;
      S_MEM_WB:   next_state = S_FETCH;
      S_MEM_WR:   next_state = S_FETCH;
      S_HALT:     next_state = S_HALT;
      default:    next_state = S_RESET;
    endcase
  end

  always_comb begin
    dp              = '0;
    dp.reg_sel      = SEL_RN;
    dp.wb_sel       = WB_C;
    mem             = '0;
    mem.sel_pc_addr = 1'b1;
    case (state)
      S_RESET: begin
        mem.load_pc  = 1'b1;
        mem.clear_pc = 1'b1;
      end
      S_FETCH: mem.load_pc = 1'b1;
      S_DECODE: begin
        // Rn goes to A early, so LDR and STR can add the offset next cycle
        mem.load_ir = 1'b1;
        dp.en_a     = 1'b1;
      end
      S_LOAD_A: dp.en_a = 1'b1;
      S_LOAD_B: begin
        dp.reg_sel = SEL_RM;
        dp.en_b    = 1'b1;
      end
      S_EXEC: begin
        if (is_mem) begin
          dp.bsel = 1'b1;
          dp.en_c = 1'b1;
          // store data register read in the same cycle as the address add
          if (is_str) begin
            dp.reg_sel = SEL_RD;
            dp.en_b    = 1'b1;
          end
        end else if (is_cmp) begin
          dp.en_status = 1'b1;
        end else begin
          dp.en_c = 1'b1;
          dp.asel = (instr.opcode == OP_MOV);
        end
      end
      S_WRITE: begin
        dp.rf_we = 1'b1;
        if (mov_imm) begin
          dp.wb_sel = WB_IMM;
        end else begin
          dp.reg_sel = SEL_RD;
        end
      end
      S_MEM_ADDR: begin
        mem.load_addr = 1'b1;
        // C swaps from address to store data
        if (is_str) begin
          dp.asel = 1'b1;
          dp.en_c = 1'b1;
        end
      end
      S_MEM_RD: mem.sel_pc_addr = 1'b0;
      S_MEM_WB: begin
        dp.rf_we   = 1'b1;
        dp.reg_sel = SEL_RD;
        dp.wb_sel  = WB_MDATA;
      end
      S_MEM_WR: begin
        mem.sel_pc_addr = 1'b0;
        mem.mem_we      = 1'b1;
      end
      default: ;
    endcase
  end

  assign halted = (state == S_HALT);

endmodule

`default_nettype wire

//--- hw/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module cpu_core
  import isa_pkg::*, ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  addr_t  start_pc,
  input  word_t  ram_rdata,
  output addr_t  ram_addr,
  output word_t  ram_wdata,
  output logic   ram_we,
  output word_t  out,
  output flags_t status,
  output logic   halted
);

  word_t          ir;
  word_t          ir_word;
  addr_t          pc;
  addr_t          dar;
  instr_t         raw;
  decoded_instr_t dec;
  dp_ctrl_t       dp;
  mem_ctrl_t      mem;

  // decode sees the fetched word while it is being latched
  assign ir_word = mem.load_ir ? ram_rdata : ir;
  assign raw     = instr_t'(ir_word);

  always_comb begin
    dec.opcode = raw.opcode;
    dec.op     = raw.op;
    dec.rn     = raw.rn;
    dec.rd     = raw.rd;
    dec.rm     = raw.rm;
    // bits 4..3 belong to the offset in LDR/STR
    if (raw.opcode == OP_MOV || raw.opcode == OP_ALU) begin
      dec.shift = raw.shift;
    end else begin
      dec.shift = SH_NONE;
    end
    dec.sximm5 = {{(`CPU_WORD_W - 5){ir_word[4]}}, ir_word[4:0]};
    dec.sximm8 = {{(`CPU_WORD_W - 8){ir_word[7]}}, ir_word[7:0]};
  end

  always_ff @(posedge clk) begin
    if (mem.load_ir) begin
      ir <= ram_rdata;
    end
    if (mem.load_pc) begin
      pc <= mem.clear_pc ? start_pc : pc + addr_t'(1);
    end
    if (mem.load_addr) begin
      dar <= out[`CPU_ADDR_W-1:0];
    end
  end

  assign ram_addr  = mem.sel_pc_addr ? pc : dar;
  assign ram_wdata = out;
  assign ram_we    = mem.mem_we;

  cpu_controller u_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .instr (dec),
    .dp    (dp),
    .mem   (mem),
    .halted(halted)
  );

  cpu_datapath u_dp (
    .clk   (clk),
    .ctrl  (dp),
    .instr (dec),
    .pc    (pc),
    .mdata (ram_rdata),
    .out   (out),
    .status(status)
  );

endmodule

`default_nettype wire

//--- hw/cpu_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module cpu_datapath
  import isa_pkg::*, ctrl_pkg::*;
(
  input  logic           clk,
  input  dp_ctrl_t       ctrl,
  input  decoded_instr_t instr,
  input  addr_t          pc,
  input  word_t          mdata,
  output word_t          out,
  output flags_t         status
);

  localparam int MSB = `CPU_WORD_W - 1;

  word_t    a_reg;
  word_t    b_reg;
  word_t    b_shift;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_y;
  word_t    rf_rdata;
  word_t    rf_wdata;
  reg_idx_t rf_addr;
  alu_op_e  alu_op;
  flags_t   alu_flags;

  always_comb begin
    case (ctrl.reg_sel)
      SEL_RD:  rf_addr = instr.rd;
      SEL_RN:  rf_addr = instr.rn;
      default: rf_addr = instr.rm;
    endcase
  end

  always_comb begin
    case (instr.shift)
      SH_LSL1: b_shift = b_reg << 1;
      SH_LSR1: b_shift = b_reg >> 1;
      SH_ASR1: b_shift = {b_reg[MSB], b_reg[MSB:1]};
      default: b_shift = b_reg;
    endcase
  end

  // only ALU-class instructions pick their own op; MOV, LDR, STR add
  assign alu_op = (instr.opcode == OP_ALU) ? instr.op : ALU_ADD;
  assign alu_a  = ctrl.asel ? '0 : a_reg;
  assign alu_b  = ctrl.bsel ? instr.sximm5 : b_shift;

  always_comb begin
    case (ctrl.wb_sel)
      WB_PC:    rf_wdata = {{(`CPU_WORD_W - `CPU_ADDR_W){1'b0}}, pc};
      WB_IMM:   rf_wdata = instr.sximm8;
      WB_MDATA: rf_wdata = mdata;
      default:  rf_wdata = out;
    endcase
  end

  reg_file u_rf (
    .clk  (clk),
    .we   (ctrl.rf_we),
    .waddr(rf_addr),
    .wdata(rf_wdata),
    .raddr(rf_addr),
    .rdata(rf_rdata)
  );

  alu u_alu (
    .a    (alu_a),
    .b    (alu_b),
    .op   (alu_op),
    .y    (alu_y),
    .flags(alu_flags)
  );

  always_ff @(posedge clk) begin
    if (ctrl.en_a) begin
      a_reg <= rf_rdata;
    end
    if (ctrl.en_b) begin
      b_reg <= rf_rdata;
    end
    if (ctrl.en_c) begin
      out <= alu_y;
    end
    if (ctrl.en_status) begin
      status <= alu_flags;
    end
  end

endmodule

`default_nettype wire

//--- hw/cpu_system.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_system
  import isa_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  addr_t  start_pc,
  input  logic   load_we,
  input  addr_t  load_addr,
  input  word_t  load_wdata,
  output word_t  load_rdata,
  output word_t  out,
  output flags_t status,
  output logic   halted
);

  addr_t ram_addr;
  word_t ram_wdata;
  word_t ram_rdata;
  logic  ram_we;

  cpu_core core (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_pc (start_pc),
    .ram_rdata(ram_rdata),
    .ram_addr (ram_addr),
    .ram_wdata(ram_wdata),
    .ram_we   (ram_we),
    .out      (out),
    .status   (status),
    .halted   (halted)
  );

  // program and data share one memory
  data_ram ram (
    .clk       (clk),
    .addr      (ram_addr),
    .wdata     (ram_wdata),
    .we        (ram_we),
    .rdata     (ram_rdata),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_wdata(load_wdata),
    .load_rdata(load_rdata)
  );

endmodule

`default_nettype wire

//--- hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  import isa_pkg::*;

  // write-back source for the register file
  typedef enum logic [1:0] {
    WB_C     = 2'b00,
    WB_PC    = 2'b01,
    WB_IMM   = 2'b10,
    WB_MDATA = 2'b11
  } wb_sel_e;

  typedef enum logic [3:0] {
    S_RESET,
    S_FETCH,
    S_DECODE,
    S_LOAD_A,
    S_LOAD_B,
    S_EXEC,
    S_WRITE,
    S_MEM_ADDR,
    S_MEM_RD,
    S_MEM_WB,
    S_MEM_WR,
    S_HALT
  } ctrl_state_e;

  typedef struct packed {
    reg_sel_e reg_sel;
    logic     rf_we;
    logic     en_a;
    logic     en_b;
    logic     en_c;
    logic     en_status;
    logic     asel;
    logic     bsel;
    wb_sel_e  wb_sel;
  } dp_ctrl_t;

  typedef struct packed {
    logic load_ir;
    logic load_pc;
    logic clear_pc;
    logic load_addr;
    logic sel_pc_addr;
    logic mem_we;
  } mem_ctrl_t;

endpackage

`default_nettype wire

//--- hw/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module data_ram
  import isa_pkg::*;
(
  input  logic  clk,
  input  addr_t addr,
  input  word_t wdata,
  input  logic  we,
  output word_t rdata,
  input  logic  load_we,
  input  addr_t load_addr,
  input  word_t load_wdata,
  output word_t load_rdata
);

  word_t mem [`CPU_RAM_DEPTH];

  always_ff @(posedge clk) begin
    // load port wins any write collision
    if (load_we) begin
      mem[load_addr] <= load_wdata;
    end else if (we) begin
      mem[addr] <= wdata;
    end
    rdata      <= mem[addr];
    load_rdata <= mem[load_addr];
  end

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package isa_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    OP_LDR  = 3'b011,
    OP_STR  = 3'b100,
    OP_ALU  = 3'b101,
    OP_MOV  = 3'b110,
    OP_HALT = 3'b111
  } opcode_e;

  // for MOV the same field picks register (00) or immediate (10) form
  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_AND = 2'b10,
    ALU_MVN = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    SH_NONE = 2'b00,
    SH_LSL1 = 2'b01,
    SH_LSR1 = 2'b10,
    SH_ASR1 = 2'b11
  } shift_op_e;

  typedef enum logic [1:0] {
    SEL_RM = 2'b00,
    SEL_RD = 2'b01,
    SEL_RN = 2'b10
  } reg_sel_e;

  // raw instruction word with the msb field first
  typedef struct packed {
    opcode_e   opcode;
    alu_op_e   op;
    reg_idx_t  rn;
    reg_idx_t  rd;
    shift_op_e shift;
    reg_idx_t  rm;
  } instr_t;

  typedef struct packed {
    opcode_e   opcode;
    alu_op_e   op;
    shift_op_e shift;
    reg_idx_t  rn;
    reg_idx_t  rd;
    reg_idx_t  rm;
    word_t     sximm5;
    word_t     sximm8;
  } decoded_instr_t;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
  } flags_t;

endpackage

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module reg_file
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     we,
  input  reg_idx_t waddr,
  input  word_t    wdata,
  input  reg_idx_t raddr,
  output word_t    rdata
);

  word_t regs [`CPU_NREGS];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // read is combinational so A/B capture the same cycle
  assign rdata = regs[raddr];

endmodule

`default_nettype wire

//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word and ram word share one width
`define CPU_WORD_W 16

// pc and data pointer span the 8-bit address space
`define CPU_ADDR_W 8

// general purpose registers r0..r7
`define CPU_NREGS 8

// one word per address
`define CPU_RAM_DEPTH 256

`endif

//--- sim/cpu_system_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module cpu_system_tb
  import isa_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int MSB = `CPU_WORD_W - 1;

  logic   clk;
  logic   rst_n;
  addr_t  start_pc;
  logic   load_we;
  addr_t  load_addr;
  word_t  load_wdata;
  word_t  load_rdata;
  word_t  out;
  flags_t status;
  logic   halted;

  int     errors = 0;
  int     test_base = 0;
  int     test_num = 0;
  int     tests_ok = 0;
  int     tests_bad = 0;
  int     total_cycles = 0;
  int     run_cycles = 0;

  // memory image of the program under test keyed by address
  word_t  image [int];
  int     next_addr;
  addr_t  prog_start;
  int     prog_cycles;
  word_t  final_out;
  flags_t final_status;
  word_t  opnd_a;
  word_t  opnd_b;

  cpu_system UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_pc  (start_pc),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_wdata(load_wdata),
    .load_rdata(load_rdata),
    .out       (out),
    .status    (status),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // run cycles only; limit grows with each loaded program
  always @(posedge clk) begin
    if (rst_n) begin
      run_cycles++;
      if (run_cycles > 10 * total_cycles) begin
        $display("timeout: halted never rose within %0d run cycles", 10 * total_cycles);
        $display("Some tests failed");
        $finish;
      end
    end
  end

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else begin
      $display("FAILED at %0t ns: halted expected 1, got %b", $time, $sampled(halted));
      errors++;
    end

  function automatic word_t mov_imm(input reg_idx_t rn, input logic [7:0] imm8);
    // op field 10 selects the immediate form
    mov_imm = {OP_MOV, 2'b10, rn, imm8};
  endfunction

  function automatic word_t mov_reg(input reg_idx_t rd, input reg_idx_t rm, input shift_op_e sh);
    mov_reg = {OP_MOV, 2'b00, 3'd0, rd, sh, rm};
  endfunction

  function automatic word_t alu_instr(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rn,
                                      input reg_idx_t rm, input shift_op_e sh);
    alu_instr = {OP_ALU, op, rn, rd, sh, rm};
  endfunction

  function automatic word_t mem_instr(input opcode_e opc, input reg_idx_t rd, input reg_idx_t rn,
                                      input int off);
    mem_instr = {opc, 2'b00, rn, rd, off[4:0]};
  endfunction

  function automatic word_t halt_instr();
    halt_instr = {OP_HALT, 13'd0};
  endfunction

  // fetch and decode included
  function automatic int instr_cycles(input word_t w);
    case (w[15:13])
      3'b110:  instr_cycles = (w[12:11] == 2'b10) ? 3 : 5;
      3'b101:  instr_cycles = (w[12:11] == 2'b00 || w[12:11] == 2'b10) ? 6 : 5;
      3'b011:  instr_cycles = 6;
      3'b100:  instr_cycles = 5;
      default: instr_cycles = 2;
    endcase
  endfunction

  function automatic word_t sign_ext8(input logic [7:0] v);
    sign_ext8 = {{(`CPU_WORD_W - 8){v[7]}}, v};
  endfunction

  function automatic word_t shifted(input word_t v, input shift_op_e sh);
    case (sh)
      SH_LSL1: shifted = {v[MSB-1:0], 1'b0};
      SH_LSR1: shifted = {1'b0, v[MSB:1]};
      SH_ASR1: shifted = {v[MSB], v[MSB:1]};
      default: shifted = v;
    endcase
  endfunction

  function automatic flags_t sub_flags(input word_t a, input word_t b);
    int    sa;
    int    sb;
    int    diff;
    word_t y;
    sa = $signed(a);
    sb = $signed(b);
    diff = sa - sb;
    y = a - b;
    sub_flags.n = y[MSB];
    sub_flags.z = (y == 0);
    sub_flags.v = (diff > 32767) || (diff < -32768);
  endfunction

  function automatic addr_t eff_addr(input word_t base, input int off);
    word_t sum;
    sum = base + word_t'(off);
    eff_addr = sum[`CPU_ADDR_W-1:0];
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
      else begin
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
      end
  endtask

  task automatic begin_program(input addr_t start);
    image.delete();
    prog_start = start;
    next_addr = start;
    prog_cycles = 1;
  endtask

  task automatic emit(input word_t instr);
    image[next_addr % `CPU_RAM_DEPTH] = instr;
    next_addr++;
    prog_cycles += instr_cycles(instr);
  endtask

  task automatic run_program();
    int addr;
    int cyc;
    total_cycles += prog_cycles;
    if (image.first(addr)) begin
      do begin
        @(posedge clk);
        load_we    <= 1'b1;
        load_addr  <= addr_t'(addr);
        load_wdata <= image[addr];
      end while (image.next(addr));
    end
    @(posedge clk);
    load_we  <= 1'b0;
    start_pc <= prog_start;
    @(posedge clk);
    @(negedge clk);
    check_value("halted", 0, halted);
    @(posedge clk);
    rst_n <= 1'b1;
    cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
      @(negedge clk);
    end while (!halted);
    // halted must not rise before the program's last instruction
    check_value("cycles to halted", prog_cycles, cyc);
    final_out = out;
    final_status = status;
    repeat (3) begin
      @(negedge clk);
      check_value("halted", 1, halted);
    end
    @(posedge clk);
    rst_n <= 1'b0;
  endtask

  task automatic check_mem(input addr_t addr, input word_t expected);
    word_t value;
    @(posedge clk);
    load_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    value = load_rdata;
    check_value($sformatf("load_rdata mem[%02h]", addr), expected, value);
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors == test_base) begin
      tests_ok++;
      $display("test %0d (%s): ok", test_num, name);
    end else begin
      tests_bad++;
      $display("test %0d (%s): %0d error(s)", test_num, name, errors - test_base);
    end
    test_base = errors;
  endtask

  task automatic halt_flag_test();
    begin_program(8'h00);
    emit(mov_imm(3'd0, 8'h05));
    emit(mov_imm(3'd7, 8'h30));
    emit(mem_instr(OP_STR, 3'd0, 3'd7, 0));
    emit(halt_instr());
    run_program();
    check_mem(8'h30, 16'h0005);
    end_test("halted flag");
  endtask

  task automatic mov_test();
    logic [7:0] imm_neg;
    logic [7:0] imm_pos;
    imm_neg = 8'h80 | 8'($urandom);
    imm_pos = 8'h7f & 8'($urandom);
    begin_program(8'h00);
    emit(mov_imm(3'd1, imm_neg));
    emit(mov_imm(3'd2, imm_pos));
    emit(mov_imm(3'd7, 8'h40));
    emit(mem_instr(OP_STR, 3'd1, 3'd7, 0));
    emit(mem_instr(OP_STR, 3'd2, 3'd7, 1));
    for (int s = 0; s < 4; s++) begin
      emit(mov_reg(3'd3, 3'd1, shift_op_e'(s)));
      emit(mem_instr(OP_STR, 3'd3, 3'd7, 2 + s));
    end
    emit(mov_reg(3'd4, 3'd2, SH_ASR1));
    emit(mem_instr(OP_STR, 3'd4, 3'd7, 6));
    emit(halt_instr());
    run_program();
    check_mem(8'h40, sign_ext8(imm_neg));
    check_mem(8'h41, sign_ext8(imm_pos));
    for (int s = 0; s < 4; s++) begin
      check_mem(addr_t'(8'h42 + s), shifted(sign_ext8(imm_neg), shift_op_e'(s)));
    end
    check_mem(8'h46, shifted(sign_ext8(imm_pos), SH_ASR1));
    check_value("out", shifted(sign_ext8(imm_pos), SH_ASR1), final_out);
    end_test("mov immediate and register");
  endtask

  task automatic build_alu_program(input addr_t start);
    begin_program(start);
    image[8'h60] = opnd_a;
    image[8'h61] = opnd_b;
    for (int i = 2; i < 6; i++) begin
      image[8'h60 + i] = '0;
    end
    emit(mov_imm(3'd7, 8'h60));
    emit(mem_instr(OP_LDR, 3'd1, 3'd7, 0));
    emit(mem_instr(OP_LDR, 3'd2, 3'd7, 1));
    emit(alu_instr(ALU_ADD, 3'd3, 3'd1, 3'd2, SH_NONE));
    emit(mem_instr(OP_STR, 3'd3, 3'd7, 2));
    emit(alu_instr(ALU_AND, 3'd4, 3'd1, 3'd2, SH_NONE));
    emit(mem_instr(OP_STR, 3'd4, 3'd7, 3));
    emit(alu_instr(ALU_ADD, 3'd6, 3'd1, 3'd2, SH_LSL1));
    emit(mem_instr(OP_STR, 3'd6, 3'd7, 5));
    emit(alu_instr(ALU_MVN, 3'd5, 3'd0, 3'd2, SH_NONE));
    emit(mem_instr(OP_STR, 3'd5, 3'd7, 4));
    emit(halt_instr());
  endtask

  task automatic check_alu_results();
    check_mem(8'h62, opnd_a + opnd_b);
    check_mem(8'h63, opnd_a & opnd_b);
    check_mem(8'h64, ~opnd_b);
    check_mem(8'h65, opnd_a + {opnd_b[MSB-1:0], 1'b0});
    check_value("out", ~opnd_b, final_out);
  endtask

  task automatic alu_test();
    opnd_a = word_t'($urandom);
    opnd_b = word_t'($urandom);
    build_alu_program(8'h00);
    run_program();
    check_alu_results();
    end_test("add, and, mvn");
  endtask

  task automatic cmp_test();
    word_t a;
    word_t b;
    for (int k = 0; k < 3; k++) begin
      case (k)
        0: begin
          a = word_t'($urandom);
          b = a;
        end
        1: begin
          a = word_t'($urandom) & 16'h0fff;
          b = a + 16'd1 + (word_t'($urandom) & 16'h00ff);
        end
        default: begin
          // negative minus positive beyond the 16-bit range
          a = 16'h8000 | (word_t'($urandom) & 16'h0fff);
          b = 16'h4000 | (word_t'($urandom) & 16'h0fff);
        end
      endcase
      begin_program(8'h00);
      image[8'h70] = a;
      image[8'h71] = b;
      emit(mov_imm(3'd7, 8'h70));
      emit(mem_instr(OP_LDR, 3'd1, 3'd7, 0));
      emit(mem_instr(OP_LDR, 3'd2, 3'd7, 1));
      emit(mov_reg(3'd3, 3'd1, SH_NONE));
      emit(alu_instr(ALU_SUB, 3'd0, 3'd1, 3'd2, SH_NONE));
      emit(halt_instr());
      run_program();
      check_value("status", {13'd0, sub_flags(a, b)}, {13'd0, final_status});
      check_value("out", a, final_out);
    end
    end_test("cmp flags");
  endtask

  task automatic offset_test();
    word_t d1;
    word_t d2;
    word_t base_lo;
    word_t base_hi;
    d1 = word_t'($urandom);
    d2 = word_t'($urandom);
    base_lo = sign_ext8(8'h02);
    base_hi = sign_ext8(8'hf8);
    begin_program(8'h20);
    image[eff_addr(base_lo, -5)] = d1;
    image[eff_addr(base_hi, -16)] = d2;
    image[eff_addr(base_lo, 15)] = '0;
    image[eff_addr(base_hi, 9)] = '0;
    image[eff_addr(base_lo, -3)] = '0;
    emit(mov_imm(3'd6, 8'h02));
    emit(mov_imm(3'd5, 8'hf8));
    emit(mem_instr(OP_LDR, 3'd1, 3'd6, -5));
    emit(mem_instr(OP_STR, 3'd1, 3'd6, 15));
    emit(mem_instr(OP_STR, 3'd1, 3'd5, 9));
    emit(mem_instr(OP_LDR, 3'd2, 3'd5, -16));
    emit(mem_instr(OP_STR, 3'd2, 3'd6, -3));
    emit(halt_instr());
    run_program();
    check_mem(eff_addr(base_lo, 15), d1);
    check_mem(eff_addr(base_hi, 9), d1);
    check_mem(eff_addr(base_lo, -3), d2);
    check_value("out", d2, final_out);
    end_test("ldr/str offsets");
  endtask

  task automatic relocate_test();
    word_t sentinel;
    sentinel = word_t'($urandom);
    build_alu_program(8'ha0);
    // old start address of the same program
    image[8'h00] = sentinel;
    run_program();
    check_alu_results();
    check_mem(8'h00, sentinel);
    end_test("relocated start_pc");
  endtask

  initial begin
    rst_n      = 1'b0;
    start_pc   = '0;
    load_we    = 1'b0;
    load_addr  = '0;
    load_wdata = '0;
    void'($urandom(32'hd6f9));
    repeat (2) @(posedge clk);
    halt_flag_test();
    mov_test();
    alu_test();
    cmp_test();
    offset_test();
    relocate_test();
    $display("tests: %0d ok, %0d with errors, %0d error(s) in total",
             tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
